// File: sim.f
+incdir+logic
logic/trace_pkg.sv
logic/trace_regs.sv
logic/pattern_matcher.sv
logic/capture_fsm.sv
logic/capture_timer.sv
logic/capture_fifo.sv
logic/trace_top.sv
tests/trace_sva.sv
tests/trace_tb.sv

// File: Makefile
# Verilator simulation of the trace sniffer

VERILATOR ?= verilator
TOP       ?= trace_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed!

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/trace_tb.sv
`include "trace_cfg.svh"

module trace_tb;
   timeunit 1ns;
   timeprecision 1ns;

   localparam int max_cycles = 20000;   // generous margin over all tests together
   localparam int ack_limit  = 16;
   localparam int complete_idx = 3;     // stream slot holding the completing nibble

   logic                 trace_clk;
   logic                 reset;
   trace_pkg::nibble_t   trace_data;
   logic                 trig_out;
   logic                 wb_cyc;
   logic                 wb_stb;
   logic                 wb_we;
   trace_pkg::reg_addr_t wb_adr;
   trace_pkg::reg_data_t wb_dat_w;
   trace_pkg::reg_data_t wb_dat_r;
   logic                 wb_ack;

   int error_count = 0;
   int check_count = 0;
   int tests_run   = 0;
   int cycle_count = 0;
   int rise_cycle;
   int high_cycles;

   // rule 0 pattern A5C3 with nibble 1 masked off, so E stands in for C
   trace_pkg::nibble_t match_seq[4] = '{4'hA, 4'h5, 4'hE, 4'h3};
   trace_pkg::nibble_t captured[$];    // trace nibbles seen while trig_out was high

   trace_top dut (
      .trace_clk (trace_clk),
      .reset     (reset),
      .trace_data(trace_data),
      .trig_out  (trig_out),
      .wb_cyc    (wb_cyc),
      .wb_stb    (wb_stb),
      .wb_we     (wb_we),
      .wb_adr    (wb_adr),
      .wb_dat_w  (wb_dat_w),
      .wb_dat_r  (wb_dat_r),
      .wb_ack    (wb_ack)
   );

   initial begin
      trace_clk = 1'b0;
      forever #50 trace_clk = ~trace_clk;
   end

   always @(posedge trace_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("Error: run stopped after %0d cycles without reaching the end", cycle_count);
         $display("Test failures found");
         $finish;
      end
   end

   task automatic check(input string name, input int actual, input int expected);
      check_count++;
      if (actual != expected) begin
         $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                  $time, name, actual, expected);
         error_count++;
      end
   endtask

   // one classic cycle with everything held until ack
   task automatic bus_cycle(input trace_pkg::reg_addr_t adr, input logic we,
                            input trace_pkg::reg_data_t wdata,
                            output trace_pkg::reg_data_t rdata);
      int waited;
      waited = 0;
      @(posedge trace_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdata;
      @(negedge trace_clk);
      while (!wb_ack && waited < ack_limit) begin
         @(negedge trace_clk);
         waited++;
      end
      if (!wb_ack) begin
         $display("Error at %0t ns: no ack for bus access to address 0x%02h", $time, adr);
         error_count++;
      end else begin
         check("wb_ack wait cycles", waited, 1);   // one wait state
      end
      rdata = wb_dat_r;   // stable mid cycle while ack is high
      @(posedge trace_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input trace_pkg::reg_addr_t adr, input trace_pkg::reg_data_t data);
      trace_pkg::reg_data_t unused;
      bus_cycle(adr, 1'b1, data, unused);
   endtask

   task automatic wb_read(input trace_pkg::reg_addr_t adr, output trace_pkg::reg_data_t data);
      bus_cycle(adr, 1'b0, 8'h00, data);
   endtask

   task automatic read_expect(input trace_pkg::reg_addr_t adr,
                              input trace_pkg::reg_data_t expected, input string name);
      trace_pkg::reg_data_t rd;
      wb_read(adr, rd);
      check(name, int'(rd), int'(expected));
   endtask

   // never returns A, so only the streamed sequence can match rule 0
   function automatic trace_pkg::nibble_t idle_nibble();
      logic [31:0] r;
      r = $urandom;
      if (r[3:0] == 4'hA)
         return 4'h2;
      return r[3:0];
   endfunction

   // match sequence then idle nibbles while watching trig_out
   task automatic stream_sequence(input int n_cycles);
      trace_pkg::nibble_t nib;
      rise_cycle  = -1;
      high_cycles = 0;
      captured.delete();
      for (int i = 0; i < n_cycles; i++) begin
         @(posedge trace_clk);
         if (i < 4)
            nib = match_seq[i];
         else
            nib = idle_nibble();
         trace_data <= nib;
         @(negedge trace_clk);
         if (trig_out) begin
            if (rise_cycle < 0)
               rise_cycle = i;
            high_cycles++;
            captured.push_back(trace_data);
         end
      end
   endtask

   task automatic setup_capture(input trace_pkg::cycles_t delay, input trace_pkg::cycles_t len,
                                input trace_pkg::reg_data_t ctrl);
      wb_write(`REG_DELAY, delay);
      wb_write(`REG_CAPLEN, len);
      wb_write(`REG_CTRL, ctrl);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      $display("%s finished with %0d errors", name, error_count - errors_before);
   endtask

   task automatic test_register_readback();
      int errs;
      trace_pkg::reg_data_t cfg[8] = '{8'hC3, 8'hA5, 8'h0F, 8'hFF, 8'h81, 8'h9E, 8'hF0, 8'hF0};
      errs = error_count;
      read_expect(`REG_STATUS, 8'h08, "status after reset");   // idle, fifo empty
      for (int i = 0; i < 8; i++)
         wb_write(trace_pkg::reg_addr_t'(`REG_PATTERN + i), cfg[i]);
      wb_write(`REG_DELAY, 8'h21);
      wb_write(`REG_CAPLEN, 8'h07);
      wb_write(`REG_RULE_EN, 8'h03);
      for (int i = 0; i < 8; i++)
         read_expect(trace_pkg::reg_addr_t'(`REG_PATTERN + i), cfg[i],
                     $sformatf("pattern/mask byte %0d", i));
      read_expect(`REG_DELAY, 8'h21, "delay");
      read_expect(`REG_CAPLEN, 8'h07, "cap_len");
      read_expect(`REG_RULE_EN, 8'h03, "rule_en");
      wb_write(`REG_RULE_EN, 8'h00);
      report_test("register readback", errs);
   endtask

   task automatic test_match_counters();
      int errs;
      errs = error_count;
      // rule 1 matches the same stream and is held off only by its enable
      wb_write(trace_pkg::reg_addr_t'(`REG_PATTERN + 4), 8'hE3);
      wb_write(trace_pkg::reg_addr_t'(`REG_PATTERN + 5), 8'hA5);
      wb_write(trace_pkg::reg_addr_t'(`REG_PATTERN + 6), 8'hFF);
      wb_write(trace_pkg::reg_addr_t'(`REG_PATTERN + 7), 8'hFF);
      wb_write(`REG_RULE_EN, 8'h01);   // rule 1 stays off
      repeat (3) stream_sequence(10);
      read_expect(trace_pkg::reg_addr_t'(`REG_COUNT + 0), 8'd3, "rule0 count");
      read_expect(trace_pkg::reg_addr_t'(`REG_COUNT + 1), 8'd0, "rule1 count");
      wb_write(`REG_CTRL, 8'h01);
      read_expect(trace_pkg::reg_addr_t'(`REG_COUNT + 0), 8'd0, "rule0 count after arm");
      read_expect(trace_pkg::reg_addr_t'(`REG_COUNT + 1), 8'd0, "rule1 count after arm");
      read_expect(`REG_STATUS, 8'h09, "status after arm");   // armed, fifo empty
      report_test("masked match and counters", errs);
   endtask

   task automatic test_trigger_delay();
      int errs;
      errs = error_count;
      // completing nibble is sampled one edge after it is driven and trig_out follows delay+2 later
      setup_capture(8'd0, 8'd3, 8'h03);
      stream_sequence(20);
      check("trig_out rise, delay 0", rise_cycle, complete_idx + 1 + 0 + 2);
      setup_capture(8'd5, 8'd3, 8'h03);
      stream_sequence(20);
      check("trig_out rise, delay 5", rise_cycle, complete_idx + 1 + 5 + 2);
      report_test("trigger delay", errs);
   endtask

   task automatic test_capture_content();
      int errs;
      trace_pkg::reg_data_t rd;
      errs = error_count;
      setup_capture(8'd2, 8'd6, 8'h03);
      stream_sequence(24);
      check("trig_out rise, delay 2", rise_cycle, complete_idx + 1 + 2 + 2);
      check("trig_out high cycles", high_cycles, 6);
      for (int i = 0; i < 6; i++) begin
         wb_read(`REG_FIFO, rd);
         check($sformatf("fifo sample %0d", i), int'(rd), int'(captured[i]));
      end
      read_expect(`REG_STATUS, 8'h0C, "status after readout");   // done, fifo empty
      report_test("capture content and length", errs);
   endtask

   task automatic test_overflow_flush();
      int errs;
      trace_pkg::reg_data_t rd;
      errs = error_count;
      setup_capture(8'd0, 8'd70, 8'h03);
      stream_sequence(90);
      check("trig_out high cycles, long capture", high_cycles, 70);
      for (int i = 0; i < 64; i++) begin
         wb_read(`REG_FIFO, rd);
         check($sformatf("fifo sample %0d", i), int'(rd), int'(captured[i]));
      end
      read_expect(`REG_STATUS, 8'h1C, "status with overflow");   // done, empty, overflow
      setup_capture(8'd0, 8'd5, 8'h01);
      read_expect(`REG_STATUS, 8'h09, "status after re-arm");    // overflow gone
      stream_sequence(20);
      read_expect(`REG_STATUS, 8'h04, "status with partial fifo");
      wb_write(`REG_CTRL, 8'h02);
      read_expect(`REG_STATUS, 8'h0C, "status after flush");
      read_expect(`REG_FIFO, 8'h00, "pop of empty fifo");
      report_test("overflow and flush", errs);
   endtask

   initial begin
      void'($urandom(50));   // one seed for all idle nibbles
      reset      = 1'b1;
      trace_data = '0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      repeat (10) @(posedge trace_clk);
      reset <= 1'b0;

      test_register_readback();
      test_match_counters();
      test_trigger_delay();
      test_capture_content();
      test_overflow_flush();

      $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: tests/trace_sva.sv
module trace_sva (
   input logic trace_clk,
   input logic reset,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack,
   input logic trig_out,
   input logic flush_pulse
);
   timeunit 1ns;
   timeprecision 1ns;

   // ack only answers a request seen on the previous edge
   ack_follows_request: assert property (
      @(posedge trace_clk) disable iff (reset)
         wb_ack |-> $past(wb_cyc && wb_stb)
   ) else $error("wb_ack without a preceding cyc/stb request");

   ack_single_cycle: assert property (
      @(posedge trace_clk) disable iff (reset)
         wb_ack |=> !wb_ack
   ) else $error("wb_ack held for more than one cycle");

   // flushing mid capture would lose samples
   no_flush_while_trigger: assert property (
      @(posedge trace_clk) disable iff (reset)
         flush_pulse |-> !trig_out
   ) else $error("fifo flushed while trig_out is high");

endmodule

bind trace_top trace_sva sva (
   .trace_clk  (trace_clk),
   .reset      (reset),
   .wb_cyc     (wb_cyc),
   .wb_stb     (wb_stb),
   .wb_ack     (wb_ack),
   .trig_out   (trig_out),
   .flush_pulse(flush_pulse)
);

// File: logic/trace_top.sv
`include "trace_cfg.svh"

module trace_top (
   input  logic                  trace_clk,
   input  logic                  reset,
   input  trace_pkg::nibble_t    trace_data,
   output logic                  trig_out,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  trace_pkg::reg_addr_t  wb_adr,
   input  trace_pkg::reg_data_t  wb_dat_w,
   output trace_pkg::reg_data_t  wb_dat_r,
   output logic                  wb_ack
);

   logic arm_pulse;
   logic flush_pulse;
   logic fifo_pop;
   logic match;
   logic timer_load;
   logic timer_zero;
   logic armed;
   logic capturing;
   logic done;
   logic fifo_empty;
   logic fifo_overflow;

   trace_pkg::rule_mask_t                     rule_en;
   trace_pkg::buffer_t [`MATCH_RULES-1:0]     patterns;
   trace_pkg::buffer_t [`MATCH_RULES-1:0]     masks;
   trace_pkg::count_t  [`MATCH_RULES-1:0]     match_counts;
   trace_pkg::cycles_t                        delay;
   trace_pkg::cycles_t                        cap_len;
   trace_pkg::cycles_t                        timer_value;
   trace_pkg::nibble_t                        fifo_rd_data;

   assign trig_out = capturing;   // trigger pulse is the capture window

   trace_regs u_regs (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .armed        (armed),
      .capturing    (capturing),
      .done         (done),
      .fifo_empty   (fifo_empty),
      .overflow     (fifo_overflow),
      .fifo_data    (fifo_rd_data),
      .match_counts (match_counts),
      .arm_pulse    (arm_pulse),
      .flush_pulse  (flush_pulse),
      .fifo_pop     (fifo_pop),
      .rule_en      (rule_en),
      .patterns     (patterns),
      .masks        (masks),
      .delay        (delay),
      .cap_len      (cap_len)
   );

   pattern_matcher u_matcher (
      .trace_clk    (trace_clk),
      .reset        (reset),
      .trace_data   (trace_data),
      .rule_en      (rule_en),
      .patterns     (patterns),
      .masks        (masks),
      .clear_counts (arm_pulse),
      .match        (match),
      .match_counts (match_counts)
   );

   capture_fsm u_fsm (
      .trace_clk   (trace_clk),
      .reset       (reset),
      .arm_pulse   (arm_pulse),
      .match       (match),
      .timer_zero  (timer_zero),
      .delay       (delay),
      .cap_len     (cap_len),
      .timer_load  (timer_load),
      .timer_value (timer_value),
      .armed       (armed),
      .capturing   (capturing),
      .done        (done)
   );

   capture_timer u_timer (
      .trace_clk (trace_clk),
      .reset     (reset),
      .load      (timer_load),
      .value     (timer_value),
      .expired   (timer_zero)
   );

   capture_fifo u_fifo (
      .trace_clk (trace_clk),
      .reset     (reset),
      .push      (capturing),
      .din       (trace_data),
      .pop       (fifo_pop),
      .flush     (flush_pulse),
      .clear_ovf (arm_pulse),
      .dout      (fifo_rd_data),
      .empty     (fifo_empty),
      .overflow  (fifo_overflow)
   );

endmodule

// File: logic/capture_fifo.sv
`include "trace_cfg.svh"

module capture_fifo (
   input  logic               trace_clk,
   input  logic               reset,
   input  logic               push,
   input  trace_pkg::nibble_t din,
   input  logic               pop,
   input  logic               flush,
   input  logic               clear_ovf,
   output trace_pkg::nibble_t dout,
   output logic               empty,
   output logic               overflow
);

   localparam int ADDR_W = $clog2(`FIFO_DEPTH);

   trace_pkg::nibble_t mem [`FIFO_DEPTH];
   logic [ADDR_W-1:0]  wr_ptr;
   logic [ADDR_W-1:0]  rd_ptr;
   logic [ADDR_W:0]    fill;    // one extra bit for full
   logic               full;
   logic               do_push;
   logic               do_pop;

   assign full    = (fill == (ADDR_W + 1)'(`FIFO_DEPTH));
   assign empty   = (fill == '0);
   assign do_push = push & ~full & ~flush;
   assign do_pop  = pop & ~empty & ~flush;

   always_ff @(posedge trace_clk) begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

   always_ff @(posedge trace_clk) begin
      if (reset || flush) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         fill <= fill + (ADDR_W + 1)'(do_push) - (ADDR_W + 1)'(do_pop);
      end
   end

   // sticky until the next arm, flush leaves it alone
   always_ff @(posedge trace_clk) begin
      if (reset)
         overflow <= 1'b0;
      else if (clear_ovf)
         overflow <= 1'b0;
      else if (push && full && !flush)
         overflow <= 1'b1;
   end

   assign dout = empty ? '0 : mem[rd_ptr];   // empty reads back as 0

endmodule

// File: logic/capture_timer.sv
module capture_timer (
   input  logic               trace_clk,
   input  logic               reset,
   input  logic               load,
   input  trace_pkg::cycles_t value,
   output logic               expired
);

   trace_pkg::cycles_t count;

   // Loading value-1 makes the zero count land on the last cycle of the
   // interval, so the sequencer leaves the state exactly value edges later.
   always_ff @(posedge trace_clk) begin
      if (reset)
         count <= '0;
      else if (load)
         count <= value - 8'd1;
      else if (count != '0)
         count <= count - 8'd1;   // hold at zero
   end

   assign expired = (count == '0);

endmodule

// File: logic/capture_fsm.sv
module capture_fsm (
   input  logic               trace_clk,
   input  logic               reset,
   input  logic               arm_pulse,
   input  logic               match,
   input  logic               timer_zero,
   input  trace_pkg::cycles_t delay,
   input  trace_pkg::cycles_t cap_len,
   output logic               timer_load,
   output trace_pkg::cycles_t timer_value,
   output logic               armed,
   output logic               capturing,
   output logic               done
);

   trace_pkg::capture_state_t state;
   trace_pkg::capture_state_t state_nxt;

   always_ff @(posedge trace_clk) begin
      if (reset)
         state <= trace_pkg::st_idle;
      else
         state <= state_nxt;
   end

   always_comb begin
      state_nxt  = state;
      timer_load = 1'b0;
      case (state)
         trace_pkg::st_armed: if (match) begin
            timer_load = 1'b1;
            // zero delay skips straight into the capture window
            state_nxt = (delay == '0) ? trace_pkg::st_capture : trace_pkg::st_delay;
         end
         trace_pkg::st_delay: if (timer_zero) begin
            timer_load = 1'b1;   // reload with capture length
            state_nxt  = trace_pkg::st_capture;
         end
         trace_pkg::st_capture: if (timer_zero) begin
            state_nxt = trace_pkg::st_done;
         end
         default: ;   // idle and done wait for arm
      endcase
      // arm wins from any state
      if (arm_pulse) begin
         state_nxt  = trace_pkg::st_armed;
         timer_load = 1'b0;
      end
   end

   // delay only matters when leaving armed
   assign timer_value = (state == trace_pkg::st_armed && delay != '0) ? delay : cap_len;

   assign armed     = (state == trace_pkg::st_armed);
   assign capturing = (state == trace_pkg::st_capture);
   assign done      = (state == trace_pkg::st_done);

endmodule

// File: logic/pattern_matcher.sv
`include "trace_cfg.svh"

module pattern_matcher (
   input  logic                                  trace_clk,
   input  logic                                  reset,
   input  trace_pkg::nibble_t                    trace_data,
   input  trace_pkg::rule_mask_t                 rule_en,
   input  trace_pkg::buffer_t [`MATCH_RULES-1:0] patterns,
   input  trace_pkg::buffer_t [`MATCH_RULES-1:0] masks,
   input  logic                                  clear_counts,
   output logic                                  match,
   output trace_pkg::count_t [`MATCH_RULES-1:0]  match_counts
);

   localparam int BUF_W = `TRACE_NIBBLE_W * `BUF_NIBBLES;

   trace_pkg::buffer_t    shift_buf;
   trace_pkg::rule_mask_t hit;

   // newest sample shifts in at the bottom
   always_ff @(posedge trace_clk) begin
      if (reset)
         shift_buf <= '0;
      else
         shift_buf <= {shift_buf[BUF_W-`TRACE_NIBBLE_W-1:0], trace_data};
   end

   // masked compare, only bits with mask=1 count
   always_comb begin
      for (int r = 0; r < `MATCH_RULES; r++) begin
         hit[r] = rule_en[r] && ((shift_buf & masks[r]) == (patterns[r] & masks[r]));
      end
   end

   always_ff @(posedge trace_clk) begin
      if (reset)
         match <= 1'b0;
      else
         match <= |hit;   // any enabled rule
   end

   // per rule counters, stick at 255
   always_ff @(posedge trace_clk) begin
      if (reset) begin
         match_counts <= '0;
      end else begin
         for (int r = 0; r < `MATCH_RULES; r++) begin
            if (clear_counts)
               match_counts[r] <= '0;
            else if (hit[r] && match_counts[r] != 8'hff)
               match_counts[r] <= match_counts[r] + 8'd1;
         end
      end
   end

endmodule

// File: logic/trace_regs.sv
`include "trace_cfg.svh"

module trace_regs (
   input  logic                                  trace_clk,
   input  logic                                  reset,
   input  logic                                  wb_cyc,
   input  logic                                  wb_stb,
   input  logic                                  wb_we,
   input  trace_pkg::reg_addr_t                  wb_adr,
   input  trace_pkg::reg_data_t                  wb_dat_w,
   output trace_pkg::reg_data_t                  wb_dat_r,
   output logic                                  wb_ack,
   input  logic                                  armed,
   input  logic                                  capturing,
   input  logic                                  done,
   input  logic                                  fifo_empty,
   input  logic                                  overflow,
   input  trace_pkg::nibble_t                    fifo_data,
   input  trace_pkg::count_t [`MATCH_RULES-1:0]  match_counts,
   output logic                                  arm_pulse,
   output logic                                  flush_pulse,
   output logic                                  fifo_pop,
   output trace_pkg::rule_mask_t                 rule_en,
   output trace_pkg::buffer_t [`MATCH_RULES-1:0] patterns,
   output trace_pkg::buffer_t [`MATCH_RULES-1:0] masks,
   output trace_pkg::cycles_t                    delay,
   output trace_pkg::cycles_t                    cap_len
);

   logic                 wr_en;
   logic                 rd_en;
   trace_pkg::reg_data_t rd_mux;

   // byte b of rule r: 0/1 pattern, 2/3 mask
   function automatic trace_pkg::reg_addr_t rule_addr(input int r, input int b);
      return trace_pkg::reg_addr_t'(`REG_PATTERN + 4 * r + b);
   endfunction

   // one wait state, ack for a single cycle
   always_ff @(posedge trace_clk) begin
      if (reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= wb_cyc & wb_stb & ~wb_ack;
   end

   assign wr_en = wb_ack & wb_cyc & wb_stb & wb_we;
   assign rd_en = wb_ack & wb_cyc & wb_stb & ~wb_we;

   // control bits act on the ack edge, never stored
   assign arm_pulse   = wr_en & (wb_adr == `REG_CTRL) & wb_dat_w[0];
   assign flush_pulse = wr_en & (wb_adr == `REG_CTRL) & wb_dat_w[1];
   assign fifo_pop    = rd_en & (wb_adr == `REG_FIFO);

   always_ff @(posedge trace_clk) begin
      if (reset) begin
         rule_en  <= '0;
         patterns <= '0;
         masks    <= '0;
         delay    <= '0;
         cap_len  <= '0;
      end else if (wr_en) begin
         case (wb_adr)
            `REG_RULE_EN: rule_en <= wb_dat_w[`MATCH_RULES-1:0];
            `REG_DELAY:   delay   <= wb_dat_w;
            `REG_CAPLEN:  cap_len <= wb_dat_w;
            default: ;
         endcase
         for (int r = 0; r < `MATCH_RULES; r++) begin
            if (wb_adr == rule_addr(r, 0))
               patterns[r][7:0] <= wb_dat_w;
            if (wb_adr == rule_addr(r, 1))
               patterns[r][15:8] <= wb_dat_w;
            if (wb_adr == rule_addr(r, 2))
               masks[r][7:0] <= wb_dat_w;
            if (wb_adr == rule_addr(r, 3))
               masks[r][15:8] <= wb_dat_w;
         end
      end
   end

   // readback, valid whenever the address is held
   always_comb begin
      rd_mux = '0;
      case (wb_adr)
         `REG_STATUS:  rd_mux = {3'b000, overflow, fifo_empty, done, capturing, armed};
         `REG_RULE_EN: rd_mux = trace_pkg::reg_data_t'(rule_en);
         `REG_DELAY:   rd_mux = delay;
         `REG_CAPLEN:  rd_mux = cap_len;
         `REG_FIFO:    rd_mux = trace_pkg::reg_data_t'(fifo_data);   // low nibble
         default:      rd_mux = '0;
      endcase
      for (int r = 0; r < `MATCH_RULES; r++) begin
         if (wb_adr == rule_addr(r, 0))
            rd_mux = patterns[r][7:0];
         if (wb_adr == rule_addr(r, 1))
            rd_mux = patterns[r][15:8];
         if (wb_adr == rule_addr(r, 2))
            rd_mux = masks[r][7:0];
         if (wb_adr == rule_addr(r, 3))
            rd_mux = masks[r][15:8];
         if (wb_adr == trace_pkg::reg_addr_t'(`REG_COUNT + r))
            rd_mux = match_counts[r];
      end
   end

   assign wb_dat_r = rd_mux;

endmodule

// File: logic/trace_pkg.sv
`include "trace_cfg.svh"

package trace_pkg;

   // one sample off the trace port
   typedef logic [`TRACE_NIBBLE_W-1:0] nibble_t;

   // shift buffer, newest nibble in the low bits
   typedef logic [`TRACE_NIBBLE_W*`BUF_NIBBLES-1:0] buffer_t;

   typedef logic [`MATCH_RULES-1:0] rule_mask_t;   // one bit per rule

   typedef logic [7:0] count_t;    // saturating match counter
   typedef logic [7:0] cycles_t;   // delay / capture length

   typedef logic [7:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;

   // capture sequencer
   typedef enum logic [2:0] {
      st_idle,
      st_armed,
      st_delay,
      st_capture,
      st_done
   } capture_state_t;

endpackage

// File: logic/trace_cfg.svh
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// trace port and matcher sizing
`define TRACE_NIBBLE_W 4
`define MATCH_RULES    2
`define BUF_NIBBLES    4    // last four samples are compared
`define FIFO_DEPTH     64

// register map, byte addresses
`define REG_CTRL    8'h00   // bit0 arm, bit1 flush
`define REG_STATUS  8'h01
`define REG_RULE_EN 8'h02
`define REG_PATTERN 8'h10   // 4 bytes per rule: pattern lo/hi, mask lo/hi
`define REG_DELAY   8'h20
`define REG_CAPLEN  8'h21
`define REG_FIFO    8'h30   // read pops one sample
`define REG_COUNT   8'h40   // one counter byte per rule

`endif
